// File: rtl/sound_map_pkg.sv
package sound_map_pkg;

	localparam int reg_sel_width = 7;

	typedef logic [reg_sel_width-1:0] reg_sel_t;

	//////////////////////////////
	// Register map
	//////////////////////////////

	// Registers per voice
	localparam reg_sel_t reg_stride = 7'd5;

	// Offsets within one voice
	localparam reg_sel_t reg_addr_lo = 7'd0;
	localparam reg_sel_t reg_addr_hi = 7'd1;
	localparam reg_sel_t reg_amp = 7'd2;
	localparam reg_sel_t reg_dur_lo = 7'd3;

	// Commit register, loads the staged values into the voice
	localparam reg_sel_t reg_dur_hi = 7'd4;

	//////////////////////////////
	// Voice numbering
	//////////////////////////////

	// Looping background track
	localparam int bg_voice = 0;

	// Voices 1 and up are one-shot effects

endpackage

// File: rtl/audio_pkg.sv
package audio_pkg;

	// Unsigned ROM samples
	localparam int sample_width = 8;
	localparam int amp_width = 4;

	localparam int rom_addr_width = 24;
	localparam int dur_width = 32;

	localparam int mix_width = 16;

	// CPU register port
	localparam int bus_width = 16;

	typedef logic [sample_width-1:0] sample_t;
	typedef logic [amp_width-1:0] amp_t;
	typedef logic [rom_addr_width-1:0] rom_addr_t;
	typedef logic [dur_width-1:0] dur_t;
	typedef logic [mix_width-1:0] mix_t;
	typedef logic [bus_width-1:0] bus_t;

endpackage

// File: rtl/voice_regs.sv
`timescale 1ns/1ns

module voice_regs import sound_map_pkg::*, audio_pkg::*; #(
	parameter int num_voices = 10
) (
	input logic clk,
	input logic rst,
	input logic en,
	input logic sample_tick,
	input logic mem_en,
	input logic memwrite,
	input reg_sel_t reg_sel,
	input bus_t writedata,
	output bus_t mem_data,
	output logic [num_voices-1:0][rom_addr_width-1:0] voice_addr,
	output logic [num_voices-1:0][amp_width-1:0] voice_amp,
	output logic [num_voices-1:0] voice_active
);

	reg_sel_t sel_voice;
	reg_sel_t sel_off;
	logic wr;
	logic rd;
	logic tick;
	logic commit;

	rom_addr_t stage_addr;
	amp_t stage_amp;
	bus_t stage_dur_lo;
	rom_addr_t loop_addr;
	dur_t loop_dur;
	dur_t new_dur;
	logic [num_voices-1:0][dur_width-1:0] voice_dur;
	bus_t rd_data;

	// Split select into voice and offset
	assign sel_voice = reg_sel / reg_stride;
	assign sel_off = reg_sel % reg_stride;

	assign wr = mem_en && memwrite;
	assign rd = mem_en && !memwrite;
	assign tick = en && sample_tick;
	assign commit = wr && sel_off == reg_dur_hi;
	assign new_dur = {writedata, stage_dur_lo};

	//////////////////////////////
	// Staging, shared by all voices
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (!rst) begin
			stage_addr <= '0;
			stage_amp <= '0;
			stage_dur_lo <= '0;
		end else if (wr) begin
			case (sel_off)
				reg_addr_lo: stage_addr[bus_width-1:0] <= writedata;
				reg_addr_hi: stage_addr[rom_addr_width-1:bus_width] <=
					writedata[rom_addr_width-bus_width-1:0];
				reg_amp: stage_amp <= writedata[amp_width-1:0];
				reg_dur_lo: stage_dur_lo <= writedata;
				default: ;
			endcase
		end
	end

	//////////////////////////////
	// Voice counters
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (!rst) begin
			voice_addr <= '0;
			voice_amp <= '0;
			voice_dur <= '0;
			voice_active <= '0;
			loop_addr <= '0;
			loop_dur <= '0;
		end else begin
			for (int v = 0; v < num_voices; v++) begin
				if (commit && sel_voice == reg_sel_t'(v)) begin
					voice_addr[v] <= stage_addr;
					voice_amp[v] <= stage_amp;
					voice_dur[v] <= new_dur;
					voice_active[v] <= new_dur != '0;
				end else if (tick) begin
					// Mask follows the count seen at this tick
					voice_active[v] <= voice_dur[v] != '0 || (v == bg_voice && loop_dur != '0);
					if (voice_dur[v] != '0) begin
						voice_addr[v] <= voice_addr[v] + 1'b1;
						voice_dur[v] <= voice_dur[v] - 1'b1;
					end else if (v == bg_voice) begin
						voice_addr[v] <= loop_addr;
						voice_dur[v] <= loop_dur;
					end
				end
			end
			// Background restart point
			if (commit && sel_voice == reg_sel_t'(bg_voice)) begin
				loop_addr <= stage_addr;
				loop_dur <= new_dur;
			end
		end
	end

	// Readback shows the live counters
	always_comb begin
		rd_data = '0;
		for (int v = 0; v < num_voices; v++) begin
			if (sel_voice == reg_sel_t'(v)) begin
				case (sel_off)
					reg_addr_lo: rd_data = voice_addr[v][bus_width-1:0];
					reg_addr_hi: rd_data = bus_t'(voice_addr[v][rom_addr_width-1:bus_width]);
					reg_amp: rd_data = bus_t'(voice_amp[v]);
					reg_dur_lo: rd_data = voice_dur[v][bus_width-1:0];
					reg_dur_hi: rd_data = voice_dur[v][dur_width-1:bus_width];
					default: rd_data = '0;
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst)
			mem_data <= '0;
		else if (rd)
			mem_data <= rd_data;
	end

endmodule

// File: rtl/sample_fetch.sv
`timescale 1ns/1ns

module sample_fetch import audio_pkg::*; #(
	parameter int num_voices = 10
) (
	input logic clk,
	input logic rst,
	input logic en,
	input logic sample_tick,
	input logic rom_ready,
	input sample_t rom_data,
	input logic [num_voices-1:0][rom_addr_width-1:0] voice_addr,
	output logic rom_load,
	output rom_addr_t rom_addr,
	output logic [num_voices-1:0][sample_width-1:0] voice_sample,
	output logic frame_done
);

	localparam int idx_width = $clog2(num_voices);

	typedef enum logic [1:0] {
		st_idle,
		st_load,
		st_wait,
		st_valid
	} state_t;

	state_t state;
	logic [idx_width-1:0] idx;
	logic last;

	assign last = idx == idx_width'(num_voices - 1);

	//////////////////////////////
	// Fetch sequencer
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (!rst) begin
			state <= st_idle;
			idx <= '0;
			frame_done <= 1'b0;
		end else begin
			frame_done <= 1'b0;
			case (state)
				st_idle: begin
					// Ticks during a frame are dropped here
					if (en && sample_tick) begin
						state <= st_load;
						idx <= '0;
					end
				end
				st_load: state <= st_wait;
				st_wait: begin
					if (rom_ready)
						state <= st_valid;
				end
				st_valid: begin
					if (last) begin
						state <= st_idle;
						frame_done <= 1'b1;
					end else begin
						state <= st_load;
						idx <= idx + 1'b1;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	assign rom_load = state == st_load;
	assign rom_addr = voice_addr[idx];

	// ROM data is valid only with rom_ready
	always_ff @(posedge clk) begin
		if (state == st_wait && rom_ready)
			voice_sample[idx] <= rom_data;
	end

endmodule

// File: rtl/voice_mixer.sv
`timescale 1ns/1ns

module voice_mixer import audio_pkg::*; #(
	parameter int num_voices = 10
) (
	input logic clk,
	input logic rst,
	input logic frame_done,
	input logic [num_voices-1:0][sample_width-1:0] voice_sample,
	input logic [num_voices-1:0][amp_width-1:0] voice_amp,
	input logic [num_voices-1:0] voice_active,
	output mix_t mix_out,
	output logic mix_valid
);

	localparam int prod_width = sample_width + amp_width;
	// Room for the full sum, always wider than the mix
	localparam int sum_width = mix_width + $clog2(num_voices);

	logic [num_voices-1:0][prod_width-1:0] prod;
	logic [sum_width-1:0] sum;
	mix_t sat;

	//////////////////////////////
	// Scale and sum
	//////////////////////////////

	always_comb begin
		sum = '0;
		for (int v = 0; v < num_voices; v++) begin
			if (voice_active[v])
				prod[v] = voice_sample[v] * voice_amp[v];
			else
				prod[v] = '0;
			sum = sum + sum_width'(prod[v]);
		end
	end

	// Clip to full scale
	assign sat = (sum[sum_width-1:mix_width] != '0) ? '1 : sum[mix_width-1:0];

	always_ff @(posedge clk) begin
		if (!rst) begin
			mix_out <= '0;
			mix_valid <= 1'b0;
		end else begin
			mix_valid <= frame_done;
			if (frame_done)
				mix_out <= sat;
		end
	end

endmodule

// File: rtl/sound_top.sv
`timescale 1ns/1ns

module sound_top import sound_map_pkg::*, audio_pkg::*; #(
	parameter int num_voices = 10
) (
	input logic clk,
	input logic rst,
	input logic en,
	input logic sample_tick,
	input logic mem_en,
	input logic memwrite,
	input reg_sel_t reg_sel,
	input bus_t writedata,
	output bus_t mem_data,
	output logic rom_load,
	output rom_addr_t rom_addr,
	input sample_t rom_data,
	input logic rom_ready,
	output mix_t mix_out,
	output logic mix_valid
);

	logic [num_voices-1:0][rom_addr_width-1:0] voice_addr;
	logic [num_voices-1:0][amp_width-1:0] voice_amp;
	logic [num_voices-1:0] voice_active;
	logic [num_voices-1:0][sample_width-1:0] voice_sample;
	logic frame_done;

	voice_regs #(
		.num_voices(num_voices)
	) u_regs (
		.clk(clk),
		.rst(rst),
		.en(en),
		.sample_tick(sample_tick),
		.mem_en(mem_en),
		.memwrite(memwrite),
		.reg_sel(reg_sel),
		.writedata(writedata),
		.mem_data(mem_data),
		.voice_addr(voice_addr),
		.voice_amp(voice_amp),
		.voice_active(voice_active)
	);

	sample_fetch #(
		.num_voices(num_voices)
	) u_fetch (
		.clk(clk),
		.rst(rst),
		.en(en),
		.sample_tick(sample_tick),
		.rom_ready(rom_ready),
		.rom_data(rom_data),
		.voice_addr(voice_addr),
		.rom_load(rom_load),
		.rom_addr(rom_addr),
		.voice_sample(voice_sample),
		.frame_done(frame_done)
	);

	voice_mixer #(
		.num_voices(num_voices)
	) u_mix (
		.clk(clk),
		.rst(rst),
		.frame_done(frame_done),
		.voice_sample(voice_sample),
		.voice_amp(voice_amp),
		.voice_active(voice_active),
		.mix_out(mix_out),
		.mix_valid(mix_valid)
	);

endmodule

// File: sim/sound_top_sva.sv
`timescale 1ns/1ns

module sound_top_sva (
	input logic clk,
	input logic rst,
	input logic rom_load,
	input logic rom_ready,
	input logic frame_done,
	input logic mix_valid
);

	// Fetch waiting on the ROM
	logic pending;
	int failures = 0;

	always_ff @(posedge clk) begin
		if (!rst)
			pending <= 1'b0;
		else if (rom_load)
			pending <= 1'b1;
		else if (rom_ready)
			pending <= 1'b0;
	end

	load_one_cycle: assert property (@(posedge clk) disable iff (!rst)
		rom_load |=> !rom_load) else begin
		$error("rom_load held longer than one cycle");
		failures++;
	end

	no_load_while_waiting: assert property (@(posedge clk) disable iff (!rst)
		pending |-> !rom_load) else begin
		$error("rom_load issued during a fetch wait");
		failures++;
	end

	// Valid cycle sits between ready and frame_done
	done_after_valid: assert property (@(posedge clk) disable iff (!rst)
		frame_done |-> $past(rom_ready, 2)) else begin
		$error("frame_done without a last valid");
		failures++;
	end

	mix_after_done: assert property (@(posedge clk) disable iff (!rst)
		frame_done |=> mix_valid) else begin
		$error("mix_valid missing after frame_done");
		failures++;
	end

endmodule

bind sound_top sound_top_sva u_sva (
	.clk(clk),
	.rst(rst),
	.rom_load(rom_load),
	.rom_ready(rom_ready),
	.frame_done(frame_done),
	.mix_valid(mix_valid)
);

// File: sim/tb_sound_top.sv
`timescale 1ns/1ns

module tb_sound_top import sound_map_pkg::*, audio_pkg::*;;

	// Enough voices for the mix to saturate
	localparam int num_voices = 20;
	localparam int clk_period = 40;
	// Worst case frame plus slack in cycles
	localparam int frame_cycles = num_voices * 10 + 20;
	localparam int margin_cycles = 2000;
	localparam string stim_file = "sim/sound_stim.txt";

	logic clk;
	logic rst;
	logic en;
	logic sample_tick;
	logic mem_en;
	logic memwrite;
	reg_sel_t reg_sel;
	bus_t writedata;
	bus_t mem_data;
	logic rom_load;
	rom_addr_t rom_addr;
	sample_t rom_data;
	logic rom_ready;
	mix_t mix_out;
	logic mix_valid;

	int errors;

	sound_top #(
		.num_voices(num_voices)
	) u_dut (
		.clk(clk),
		.rst(rst),
		.en(en),
		.sample_tick(sample_tick),
		.mem_en(mem_en),
		.memwrite(memwrite),
		.reg_sel(reg_sel),
		.writedata(writedata),
		.mem_data(mem_data),
		.rom_load(rom_load),
		.rom_addr(rom_addr),
		.rom_data(rom_data),
		.rom_ready(rom_ready),
		.mix_out(mix_out),
		.mix_valid(mix_valid)
	);

	initial begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	//////////////////////////////
	// Sample ROM model
	//////////////////////////////

	// Low byte plus three times the middle byte
	function automatic sample_t rom_byte(input rom_addr_t a);
		logic [9:0] s;
		s = 10'(a[7:0]) + 10'(a[15:8]) * 10'd3;
		return s[7:0];
	endfunction

	initial begin
		int delay;
		rom_addr_t addr;
		void'($urandom(81426));
		forever begin
			@(posedge clk);
			if (rom_load) begin
				addr = rom_addr;
				delay = 1 + int'($urandom % 8);
				repeat (delay - 1) @(posedge clk);
				rom_ready <= 1'b1;
				rom_data <= rom_byte(addr);
				@(posedge clk);
				rom_ready <= 1'b0;
			end
		end
	end

	//////////////////////////////
	// Register port and ticks
	//////////////////////////////

	task automatic write_reg(input reg_sel_t sel, input bus_t data);
		@(posedge clk);
		mem_en <= 1'b1;
		memwrite <= 1'b1;
		reg_sel <= sel;
		writedata <= data;
		@(posedge clk);
		mem_en <= 1'b0;
		memwrite <= 1'b0;
	endtask

	task automatic read_reg(input reg_sel_t sel, input bus_t expected);
		@(posedge clk);
		mem_en <= 1'b1;
		memwrite <= 1'b0;
		reg_sel <= sel;
		@(posedge clk);
		mem_en <= 1'b0;
		@(negedge clk);
		assert (mem_data == expected) else begin
			errors++;
			$display("error t=%0t mem_data sel %0d expected %h got %h",
				$time, sel, expected, mem_data);
		end
	endtask

	task automatic tick_and_check(input mix_t expected);
		int cycles;
		logic seen;
		@(posedge clk);
		sample_tick <= 1'b1;
		@(posedge clk);
		sample_tick <= 1'b0;
		cycles = 0;
		seen = 1'b0;
		while (!seen && cycles < frame_cycles) begin
			@(negedge clk);
			seen = mix_valid;
			cycles++;
		end
		assert (seen) else begin
			errors++;
			$display("No mix_valid within %0d cycles of the tick before %0t",
				frame_cycles, $time);
		end
		if (seen) begin
			assert (mix_out == expected) else begin
				errors++;
				$display("error t=%0t mix_out expected %h got %h", $time, expected, mix_out);
			end
		end
	endtask

	// No frame may follow a tick with en low
	task automatic quiet_tick();
		@(posedge clk);
		en <= 1'b0;
		sample_tick <= 1'b1;
		@(posedge clk);
		en <= 1'b1;
		sample_tick <= 1'b0;
		repeat (frame_cycles) begin
			@(negedge clk);
			assert (!mix_valid) else begin
				errors++;
				$display("A tick given with en low produced mix_valid at %0t", $time);
			end
		end
	endtask

	// Every effect voice at full scale so the sum clips
	task automatic saturation_check();
		// The tick moves each voice to address 0xff, which reads 255
		write_reg(reg_addr_lo, 16'h00fe);
		write_reg(reg_addr_hi, 16'h0000);
		write_reg(reg_amp, 16'h000f);
		write_reg(reg_dur_lo, 16'h0001);
		for (int v = 1; v < num_voices; v++)
			write_reg(reg_sel_t'(v) * reg_stride + reg_dur_hi, 16'h0000);
		tick_and_check(16'hffff);
	endtask

	//////////////////////////////
	// Main sequence
	//////////////////////////////

	initial begin
		int fd;
		int code;
		string line;
		byte cmd;
		logic [31:0] a;
		logic [31:0] b;
		errors = 0;
		rst = 1'b0;
		en = 1'b0;
		sample_tick = 1'b0;
		mem_en = 1'b0;
		memwrite = 1'b0;
		reg_sel = '0;
		writedata = '0;
		rom_data = '0;
		rom_ready = 1'b0;
		repeat (10) @(posedge clk);
		rst <= 1'b1;
		en <= 1'b1;
		fd = $fopen(stim_file, "r");
		assert (fd != 0) else begin
			errors++;
			$display("Could not open the stimulus file %s", stim_file);
		end
		if (fd != 0) begin
			while ($fgets(line, fd) != 0) begin
				code = $sscanf(line, "%c %h %h", cmd, a, b);
				if (code == 3) begin
					case (cmd)
						"w": write_reg(a[6:0], b[15:0]);
						"r": read_reg(a[6:0], b[15:0]);
						"t": repeat (a) tick_and_check(b[15:0]);
						"q": repeat (a) quiet_tick();
						default: ;
					endcase
				end
			end
			$fclose(fd);
		end
		saturation_check();
		repeat (4) @(posedge clk);
		errors += u_dut.u_sva.failures;
		$display("Errors: %0d", errors);
		if (errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

	// Watchdog sized from the ticks in the file and the saturation tick
	initial begin
		int fd;
		int ticks;
		int limit;
		string line;
		byte cmd;
		logic [31:0] a;
		logic [31:0] b;
		ticks = 0;
		fd = $fopen(stim_file, "r");
		if (fd != 0) begin
			while ($fgets(line, fd) != 0) begin
				if ($sscanf(line, "%c %h %h", cmd, a, b) == 3 && (cmd == "t" || cmd == "q"))
					ticks += int'(a);
			end
			$fclose(fd);
		end
		limit = (ticks + 1) * frame_cycles + margin_cycles;
		repeat (limit) @(posedge clk);
		$display("Watchdog expired after %0d cycles, the run did not finish", limit);
		$display("Test failed");
		$finish;
	end

endmodule

// File: sim/sound_stim.txt
# cmd arg1 arg2 in hex: w sel data | r sel expected | t ticks mix | q ticks(en low) 0
# readback on voice 9, amplitude keeps 4 bits
w 2d beef
w 2e 00a5
w 2f 00fc
w 30 5678
w 31 0001
r 2d beef
r 2e 00a5
r 2f 000c
r 30 5678
r 31 0001
w 30 0000
w 31 0000
r 31 0000
# one-shot voice 1 at 0x000010, amp 2, 3 ticks
w 05 0010
w 06 0000
w 07 0002
w 08 0003
w 09 0000
t 1 0022
t 1 0024
t 1 0026
t 2 0000
r 05 0013
r 08 0000
# background voice 0 at 0x000200, amp 3, 2 ticks then loop
w 00 0200
w 01 0000
w 02 0003
w 03 0002
w 04 0000
t 1 0015
t 1 0018
t 1 0012
t 1 0015
t 1 0018
t 1 0012
q 2 0000
r 00 0200
r 03 0002
t 1 0015
# voices 1 to 3 mixed with the background
w 05 1000
w 06 0000
w 07 0005
w 08 0004
w 09 0000
w 0a ff00
w 0b 0000
w 0c 000f
w 0d 0004
w 0e 0000
w 0f 0080
w 10 0001
w 11 0001
w 12 0004
w 13 0000
t 1 1070
t 1 107f
t 1 0197
t 1 01af
t 1 0012

// File: sound_top.f
rtl/sound_map_pkg.sv
rtl/audio_pkg.sv
rtl/voice_regs.sv
rtl/sample_fetch.sv
rtl/voice_mixer.sv
rtl/sound_top.sv
sim/sound_top_sva.sv
sim/tb_sound_top.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= tb_sound_top
FILELIST ?= sound_top.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert

BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS"

$(BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

test: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || echo "Test failed" >> $(LOG)
	@cat $(LOG)
	@if grep -q "Test failed" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
